/* image_buffer_pkg.sv */
package image_buffer_pkg;

    // Byte addresses cover the whole frame buffer, word addresses drop the lane bits
    localparam int BYTE_ADDRESS_BITS = 16;
    localparam int WORD_ADDRESS_BITS = 14;

    // RAM geometry
    localparam int BUFFER_WORDS = 16384;
    localparam int WORD_BITS = 32;
    localparam int PIXEL_BITS = 8;

    // Cycles from an address on the RAM port to its data on ram_read_data
    localparam int LRAM_LATENCY = 2;

    // Which user drove the RAM port in the previous read clock cycle
    typedef enum logic [1:0] {
        OWNER_IDLE  = 2'd0,
        OWNER_WRITE = 2'd1,
        OWNER_READ  = 2'd2
    } buffer_owner_t;

endpackage

/* inferred_lram.sv */
module inferred_lram
    import image_buffer_pkg::*;
(
    input  logic                         read_clock_in,
    input  logic [WORD_ADDRESS_BITS-1:0] ram_address,
    input  logic [WORD_BITS-1:0]         ram_write_data,
    input  logic                         ram_write_enable,
    output logic [WORD_BITS-1:0]         ram_read_data
);

    // Large RAM block, clocked from the fast read domain
    (* ram_style = "huge" *) logic [WORD_BITS-1:0] mem [0:BUFFER_WORDS-1];

    logic [WORD_BITS-1:0] read_stage;

    always_ff @(posedge read_clock_in) begin
        if (ram_write_enable) begin
            mem[ram_address] <= ram_write_data;
        end

        // Two registers on the read side give the LRAM_LATENCY of the port
        read_stage <= mem[ram_address];
        ram_read_data <= read_stage;
    end

endmodule

/* pixel_packer.sv */
module pixel_packer
    import image_buffer_pkg::*;
(
    input  logic                         write_clock_in,
    input  logic                         write_reset_n_in,
    input  logic [PIXEL_BITS-1:0]        pixel_in,
    input  logic                         pixel_valid_in,
    input  logic                         frame_start_in,
    output logic [BYTE_ADDRESS_BITS-1:0] write_address,
    output logic [WORD_BITS-1:0]         write_data,
    output logic                         write_request
);

    logic [1:0]                   lane;
    logic [WORD_BITS-1:0]         assembly;
    logic [BYTE_ADDRESS_BITS-1:0] next_address;
    logic                         request_second;
    logic                         word_done;

    // A frame start wins over a pixel that arrives in the same cycle
    assign word_done = pixel_valid_in && !frame_start_in && (lane == 2'd3);

    always_ff @(posedge write_clock_in) begin
        if (!write_reset_n_in) begin
            lane <= 2'd0;
            next_address <= '0;
            write_request <= 1'b0;
            request_second <= 1'b0;
        end else begin
            if (frame_start_in) begin
                // Any partial word is simply forgotten here
                lane <= 2'd0;
                next_address <= '0;
            end else if (pixel_valid_in) begin
                lane <= lane + 2'd1;
                if (lane == 2'd3) begin
                    next_address <= next_address + BYTE_ADDRESS_BITS'(4);
                end
            end

            // The request level stays up for two write clocks per word
            if (word_done) begin
                write_request <= 1'b1;
                request_second <= 1'b1;
            end else if (request_second) begin
                request_second <= 1'b0;
            end else begin
                write_request <= 1'b0;
            end
        end
    end

    // Bytes enter at the top and move down, so the first pixel ends in bits 7..0
    always_ff @(posedge write_clock_in) begin
        if (pixel_valid_in) begin
            assembly <= {pixel_in, assembly[WORD_BITS-1:PIXEL_BITS]};
        end

        if (word_done) begin
            write_data <= {pixel_in, assembly[WORD_BITS-1:PIXEL_BITS]};
            write_address <= next_address;
        end
    end

endmodule

/* write_synchronizer.sv */
module write_synchronizer
    import image_buffer_pkg::*;
(
    input  logic                         read_clock_in,
    input  logic                         read_reset_n_in,
    input  logic [BYTE_ADDRESS_BITS-1:0] write_address,
    input  logic [WORD_BITS-1:0]         write_data,
    input  logic                         write_request,
    output logic [WORD_ADDRESS_BITS-1:0] write_word_address,
    output logic [WORD_BITS-1:0]         write_word,
    output logic                         write_strobe
);

    logic [2:0] request_sync;
    logic       request_rise;

    // Rising edge seen between the two older flops of the chain
    assign request_rise = (request_sync[2:1] == 2'b01);

    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            request_sync <= 3'b000;
            write_strobe <= 1'b0;
        end else begin
            request_sync <= {request_sync[1:0], write_request};
            write_strobe <= request_rise;
        end
    end

    // Address and data are held steady by the packer well past this capture
    always_ff @(posedge read_clock_in) begin
        if (request_rise) begin
            write_word_address <= write_address[BYTE_ADDRESS_BITS-1:2];
            write_word <= write_data;
        end
    end

endmodule

/* host_reader.sv */
module host_reader
    import image_buffer_pkg::*;
(
    input  logic                         read_clock_in,
    input  logic                         read_reset_n_in,
    input  logic                         read_request_in,
    input  logic [BYTE_ADDRESS_BITS-1:0] read_address_in,
    input  logic                         read_grant,
    input  logic [WORD_BITS-1:0]         ram_read_data,
    output logic                         read_request,
    output logic [WORD_ADDRESS_BITS-1:0] read_word_address,
    output logic                         busy_out,
    output logic                         read_valid_out,
    output logic [PIXEL_BITS-1:0]        read_data_out
);

    logic [BYTE_ADDRESS_BITS-1:0] read_address;
    logic                         waiting;
    logic [1:0]                   delay_count;
    logic                         accept;
    logic                         capture;

    // New requests only count while the reader is idle
    assign accept = read_request_in && !busy_out;
    assign capture = waiting && (delay_count == 2'd0);

    assign read_word_address = read_address[BYTE_ADDRESS_BITS-1:2];

    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            busy_out <= 1'b0;
            read_request <= 1'b0;
            waiting <= 1'b0;
            delay_count <= 2'd0;
            read_valid_out <= 1'b0;
        end else begin
            read_valid_out <= 1'b0;

            if (accept) begin
                busy_out <= 1'b1;
                read_request <= 1'b1;
            end

            if (read_grant) begin
                // The address is on the RAM now, so wait out its latency
                read_request <= 1'b0;
                waiting <= 1'b1;
                delay_count <= 2'(LRAM_LATENCY - 1);
            end else if (capture) begin
                waiting <= 1'b0;
                busy_out <= 1'b0;
                read_valid_out <= 1'b1;
            end else if (waiting) begin
                delay_count <= delay_count - 2'd1;
            end
        end
    end

    always_ff @(posedge read_clock_in) begin
        if (accept) begin
            read_address <= read_address_in;
        end

        // Low two address bits pick the byte lane of the word
        if (capture) begin
            read_data_out <= ram_read_data[read_address[1:0] * PIXEL_BITS +: PIXEL_BITS];
        end
    end

endmodule

/* buffer_arbiter.sv */
module buffer_arbiter
    import image_buffer_pkg::*;
(
    input  logic                         read_clock_in,
    input  logic                         read_reset_n_in,
    input  logic                         write_strobe,
    input  logic [WORD_ADDRESS_BITS-1:0] write_word_address,
    input  logic [WORD_BITS-1:0]         write_word,
    input  logic                         read_request,
    input  logic [WORD_ADDRESS_BITS-1:0] read_word_address,
    output logic                         read_grant,
    output logic [WORD_ADDRESS_BITS-1:0] ram_address,
    output logic [WORD_BITS-1:0]         ram_write_data,
    output logic                         ram_write_enable
);

    buffer_owner_t owner;

    // The writer always wins, and a read is never granted two cycles running
    assign read_grant = read_request && !write_strobe && (owner != OWNER_READ);

    always_comb begin
        ram_write_data = write_word;
        if (write_strobe) begin
            ram_address = write_word_address;
            ram_write_enable = 1'b1;
        end else begin
            ram_address = read_word_address;
            ram_write_enable = 1'b0;
        end
    end

    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            owner <= OWNER_IDLE;
        end else if (write_strobe) begin
            owner <= OWNER_WRITE;
        end else if (read_grant) begin
            owner <= OWNER_READ;
        end else begin
            owner <= OWNER_IDLE;
        end
    end

endmodule

/* image_buffer.sv */
module image_buffer
    import image_buffer_pkg::*;
(
    input  logic                         write_clock_in,
    input  logic                         write_reset_n_in,
    input  logic                         read_clock_in,
    input  logic                         read_reset_n_in,
    input  logic [PIXEL_BITS-1:0]        pixel_in,
    input  logic                         pixel_valid_in,
    input  logic                         frame_start_in,
    input  logic                         read_request_in,
    input  logic [BYTE_ADDRESS_BITS-1:0] read_address_in,
    output logic                         busy_out,
    output logic                         read_valid_out,
    output logic [PIXEL_BITS-1:0]        read_data_out
);

    // Write clock domain side of the crossing
    logic [BYTE_ADDRESS_BITS-1:0] write_address;
    logic [WORD_BITS-1:0]         write_data;
    logic                         write_request;

    // Read clock domain
    logic [WORD_ADDRESS_BITS-1:0] write_word_address;
    logic [WORD_BITS-1:0]         write_word;
    logic                         write_strobe;
    logic                         read_request;
    logic [WORD_ADDRESS_BITS-1:0] read_word_address;
    logic                         read_grant;
    logic [WORD_ADDRESS_BITS-1:0] ram_address;
    logic [WORD_BITS-1:0]         ram_write_data;
    logic                         ram_write_enable;
    logic [WORD_BITS-1:0]         ram_read_data;

    pixel_packer pixel_packer_i (
        .write_clock_in   (write_clock_in),
        .write_reset_n_in (write_reset_n_in),
        .pixel_in         (pixel_in),
        .pixel_valid_in   (pixel_valid_in),
        .frame_start_in   (frame_start_in),
        .write_address    (write_address),
        .write_data       (write_data),
        .write_request    (write_request)
    );

    write_synchronizer write_synchronizer_i (
        .read_clock_in      (read_clock_in),
        .read_reset_n_in    (read_reset_n_in),
        .write_address      (write_address),
        .write_data         (write_data),
        .write_request      (write_request),
        .write_word_address (write_word_address),
        .write_word         (write_word),
        .write_strobe       (write_strobe)
    );

    buffer_arbiter buffer_arbiter_i (
        .read_clock_in      (read_clock_in),
        .read_reset_n_in    (read_reset_n_in),
        .write_strobe       (write_strobe),
        .write_word_address (write_word_address),
        .write_word         (write_word),
        .read_request       (read_request),
        .read_word_address  (read_word_address),
        .read_grant         (read_grant),
        .ram_address        (ram_address),
        .ram_write_data     (ram_write_data),
        .ram_write_enable   (ram_write_enable)
    );

    host_reader host_reader_i (
        .read_clock_in     (read_clock_in),
        .read_reset_n_in   (read_reset_n_in),
        .read_request_in   (read_request_in),
        .read_address_in   (read_address_in),
        .read_grant        (read_grant),
        .ram_read_data     (ram_read_data),
        .read_request      (read_request),
        .read_word_address (read_word_address),
        .busy_out          (busy_out),
        .read_valid_out    (read_valid_out),
        .read_data_out     (read_data_out)
    );

    // The RAM runs on the faster read clock
    inferred_lram inferred_lram_i (
        .read_clock_in    (read_clock_in),
        .ram_address      (ram_address),
        .ram_write_data   (ram_write_data),
        .ram_write_enable (ram_write_enable),
        .ram_read_data    (ram_read_data)
    );

endmodule

/* image_buffer_tb.sv */
module image_buffer_tb
    import image_buffer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int READ_TIMEOUT_CYCLES = 64;
    localparam int CYCLES_PER_LINE = 200;

    bit                           read_clock_in;
    bit                           write_clock_in;
    logic                         read_reset_n_in;
    logic                         write_reset_n_in;
    logic [PIXEL_BITS-1:0]        pixel_in;
    logic                         pixel_valid_in;
    logic                         frame_start_in;
    logic                         read_request_in;
    logic [BYTE_ADDRESS_BITS-1:0] read_address_in;
    logic                         busy_out;
    logic                         read_valid_out;
    logic [PIXEL_BITS-1:0]        read_data_out;

    // Pixel entries for the write domain; the top bit marks a frame start
    logic [PIXEL_BITS:0]          pixel_queue [$];
    logic [PIXEL_BITS-1:0]        shadow [0:(1 << BYTE_ADDRESS_BITS) - 1];
    logic [BYTE_ADDRESS_BITS-1:0] pack_position;
    logic [PIXEL_BITS-1:0]        last_byte;
    int                           valid_count;
    int                           vector_lines;
    int                           seed = 32'h42819d1f;
    string                        test_name = "reset_state";

    always #5 read_clock_in = ~read_clock_in;
    always #20 write_clock_in = ~write_clock_in;

    image_buffer image_buffer_i (
        .write_clock_in   (write_clock_in),
        .write_reset_n_in (write_reset_n_in),
        .read_clock_in    (read_clock_in),
        .read_reset_n_in  (read_reset_n_in),
        .pixel_in         (pixel_in),
        .pixel_valid_in   (pixel_valid_in),
        .frame_start_in   (frame_start_in),
        .read_request_in  (read_request_in),
        .read_address_in  (read_address_in),
        .busy_out         (busy_out),
        .read_valid_out   (read_valid_out),
        .read_data_out    (read_data_out)
    );

    // Read responses are counted mid-cycle, away from the edge that updates them
    always @(negedge read_clock_in) begin
        if (read_valid_out) begin
            valid_count <= valid_count + 1;
            last_byte <= read_data_out;
        end
    end

    // One queue entry goes out per write clock
    initial begin
        logic [PIXEL_BITS:0] entry;
        pixel_in = '0;
        pixel_valid_in = 1'b0;
        frame_start_in = 1'b0;
        forever begin
            @(negedge write_clock_in);
            if (pixel_queue.size() > 0) begin
                entry = pixel_queue.pop_front();
                frame_start_in = entry[PIXEL_BITS];
                pixel_valid_in = !entry[PIXEL_BITS];
                pixel_in = entry[PIXEL_BITS-1:0];
            end else begin
                frame_start_in = 1'b0;
                pixel_valid_in = 1'b0;
            end
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s: %s expected %0h actual %0h",
                                test_name, what, expected, actual));
        end
    endtask

    function automatic string trim_line(input string text);
        string result;
        result = text;
        while (result.len() > 0 && (result[result.len()-1] == "\n" ||
               result[result.len()-1] == "\r" || result[result.len()-1] == " ")) begin
            result = result.substr(0, result.len() - 2);
        end
        return result;
    endfunction

    // A second request, when asked for, is driven while the reader is busy
    task automatic run_read(input logic [BYTE_ADDRESS_BITS-1:0] address,
                            input logic [PIXEL_BITS-1:0] expected, input bit checked,
                            input bit second, input logic [BYTE_ADDRESS_BITS-1:0] second_address);
        int start_count;
        int waited;
        start_count = valid_count;
        waited = 0;
        @(negedge read_clock_in);
        read_request_in = 1'b1;
        read_address_in = address;
        @(negedge read_clock_in);
        if (second) begin
            check_value("busy_out at second request", 32'd1, {31'd0, busy_out});
            read_address_in = second_address;
            @(negedge read_clock_in);
        end
        read_request_in = 1'b0;
        while (valid_count == start_count && waited < READ_TIMEOUT_CYCLES) begin
            @(negedge read_clock_in);
            waited++;
        end
        if (valid_count == start_count) begin
            abort_run($sformatf("No read response for address %h within %0d read cycles",
                                address, READ_TIMEOUT_CYCLES));
        end
        // A stray extra response would show up well inside this window
        repeat (12) @(negedge read_clock_in);
        check_value("read_valid_out count", start_count + 1, valid_count);
        if (checked) begin
            check_value($sformatf("byte at %h", address), {24'd0, expected}, {24'd0, last_byte});
        end
    endtask

    initial begin
        int                           fd;
        int                           code;
        int                           line_number;
        int                           line_total;
        string                        line;
        byte                          command;
        logic [31:0]                  field_a;
        logic [31:0]                  field_b;
        logic [31:0]                  field_c;
        logic [31:0]                  random_word;
        logic [BYTE_ADDRESS_BITS-1:0] address;

        read_reset_n_in = 1'b0;
        write_reset_n_in = 1'b0;
        read_request_in = 1'b0;
        read_address_in = '0;
        pack_position = '0;
        line_number = 0;
        line_total = 0;

        // Count the lines first so that the watchdog can size its limit
        fd = $fopen("image_buffer_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open image_buffer_vectors.txt for reading");
        end
        while ($fgets(line, fd) != 0) begin
            line_total++;
        end
        $fclose(fd);
        vector_lines = line_total;
        fd = $fopen("image_buffer_vectors.txt", "r");

        repeat (16) @(negedge read_clock_in);
        read_reset_n_in = 1'b1;
        @(negedge write_clock_in);
        write_reset_n_in = 1'b1;
        @(negedge read_clock_in);
        check_value("read_valid_out after reset", 32'd0, {31'd0, read_valid_out});
        check_value("busy_out after reset", 32'd0, {31'd0, busy_out});

        while ($fgets(line, fd) != 0) begin
            line_number++;
            line = trim_line(line);
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            command = line[0];
            case (command)
                "T": test_name = line.substr(2, line.len() - 1);
                "F": begin
                    pixel_queue.push_back({1'b1, 8'h00});
                    pack_position = '0;
                end
                "P": begin
                    code = $sscanf(line, "P %h", field_a);
                    pixel_queue.push_back({1'b0, field_a[PIXEL_BITS-1:0]});
                    shadow[pack_position] = field_a[PIXEL_BITS-1:0];
                    pack_position = pack_position + 16'd1;
                end
                "G": begin
                    code = $sscanf(line, "G %d", field_a);
                    repeat (field_a) begin
                        random_word = $random(seed);
                        pixel_queue.push_back({1'b0, random_word[PIXEL_BITS-1:0]});
                        shadow[pack_position] = random_word[PIXEL_BITS-1:0];
                        pack_position = pack_position + 16'd1;
                    end
                end
                "W": begin
                    code = $sscanf(line, "W %d", field_a);
                    repeat (field_a) @(negedge write_clock_in);
                end
                "R": begin
                    code = $sscanf(line, "R %h %h", field_a, field_b);
                    address = field_a[BYTE_ADDRESS_BITS-1:0];
                    if (code == 2) begin
                        run_read(address, field_b[PIXEL_BITS-1:0], 1'b1, 1'b0, '0);
                    end else if (line[line.len()-1] == "S") begin
                        run_read(address, shadow[address], 1'b1, 1'b0, '0);
                    end else begin
                        run_read(address, '0, 1'b0, 1'b0, '0);
                    end
                end
                "B": begin
                    code = $sscanf(line, "B %h %h %h", field_a, field_b, field_c);
                    run_read(field_a[BYTE_ADDRESS_BITS-1:0], field_b[PIXEL_BITS-1:0], 1'b1,
                             1'b1, field_c[BYTE_ADDRESS_BITS-1:0]);
                end
                default: abort_run($sformatf("Unknown command on vector line %0d", line_number));
            endcase
        end
        $fclose(fd);

        while (pixel_queue.size() > 0) begin
            @(negedge write_clock_in);
        end
        $display("Simulation passed");
        $finish;
    end

    // Generous budget per vector line on top of the reset time
    initial begin
        wait (vector_lines > 0);
        repeat (16 + vector_lines * CYCLES_PER_LINE) @(posedge read_clock_in);
        abort_run($sformatf("Timeout: vectors did not finish within %0d read cycles",
                            16 + vector_lines * CYCLES_PER_LINE));
    end

endmodule

/* image_buffer_vectors.txt */
# Commands: T name | F | P byte | G count | W write_cycles
# R address expected (hex, S for the shadow array, N for no check) | B address expected second_address
T reset_state
R 0100 N
T write_read_back
F
P 11
P 22
P 33
P 44
P 55
P 66
P 77
P 88
W 8
R 0000 11
R 0001 22
R 0002 33
R 0003 44
R 0006 77
T frame_start
F
P a0
P a1
P a2
P a3
P b0
P b1
F
W 8
R 0000 a0
R 0003 a3
R 0004 55
R 0005 66
T busy
B 0003 a3 0005
T read_while_writing
F
G 48
W 20
R 0000 S
R 0001 S
R 0002 S
R 0003 S
R 0006 S
R 0009 S
W 40
R 0020 S
R 002f S

/* sources.f */
image_buffer_pkg.sv
inferred_lram.sv
pixel_packer.sv
write_synchronizer.sv
host_reader.sv
buffer_arbiter.sv
image_buffer.sv
image_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module image_buffer_tb -f sources.f \
    && ./obj_dir/Vimage_buffer_tb > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && exit 0 || exit 1
